// File: source/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// 8-byte block, 32 lines, 32-bit address
`define DCACHE_OFFSET_BITS 3
`define DCACHE_INDEX_BITS  5
`define DCACHE_TAG_BITS    24

`define MSHR_ENTRIES       4
`define MSHR_TARGET_DEPTH  4
`define LQ_IDX_BITS        3

// tag zero means no transaction
`define MEM_TAG_BITS       4

`endif

// File: source/dcache_mem_pkg.sv
`include "dcache_settings.svh"

package dcache_mem_pkg;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_command_t;

    typedef logic [31:0] addr_t;

    // one cache block, as memory moves it
    typedef logic [(8 << `DCACHE_OFFSET_BITS)-1:0] mem_block_t;

    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

endpackage

// File: source/dcache_req_pkg.sv
`include "dcache_settings.svh"

package dcache_req_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_func_t;

    typedef enum logic {
        TARGET_LOAD,
        TARGET_STORE
    } target_kind_t;

    // one waiting access behind a miss
    typedef struct packed {
        target_kind_t                   kind;
        mem_func_t                      size;
        logic [31:0]                    data;
        logic [`DCACHE_OFFSET_BITS-1:0] offset;
        logic [`LQ_IDX_BITS-1:0]        lq_idx;
    } mshr_target_t;

    function automatic dcache_mem_pkg::mem_block_t merge_store(
        input dcache_mem_pkg::mem_block_t     block,
        input mem_func_t                      size,
        input logic [`DCACHE_OFFSET_BITS-1:0] offset,
        input logic [31:0]                    data
    );
        dcache_mem_pkg::mem_block_t merged;
        merged = block;
        case (size)
            MEM_BYTE: merged[offset*8 +: 8] = data[7:0];
            MEM_HALF: merged[offset[2:1]*16 +: 16] = data[15:0];
            MEM_WORD: merged[offset[2]*32 +: 32] = data;
            default:  merged = block;
        endcase
        return merged;
    endfunction

endpackage

// File: source/mshr_target_queue.sv
`include "dcache_settings.svh"

module mshr_target_queue (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  logic                                                 push,
    input  dcache_req_pkg::mshr_target_t                         push_target,
    input  logic                                                 flush,
    output logic                                                 push_accept,
    output dcache_req_pkg::mshr_target_t [`MSHR_TARGET_DEPTH-1:0] drain_targets,
    output logic [`MSHR_TARGET_DEPTH-1:0]                        drain_valid
);
    import dcache_req_pkg::*;

    localparam int DEPTH    = `MSHR_TARGET_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    mshr_target_t        slots [DEPTH];
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS:0]   count;

    assign push_accept = push && !flush && count < (PTR_BITS+1)'(DEPTH);

    // oldest target first
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            drain_targets[i] = slots[i];
            drain_valid[i]   = flush && (PTR_BITS+1)'(i) < count;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            tail  <= '0;
            count <= '0;
        end else if (push_accept) begin
            tail  <= tail + 1'b1;
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (push_accept) begin
            slots[tail] <= push_target;
        end
    end

    // a full queue never takes another target
    assert property (@(posedge clock) disable iff (reset)
        count <= (PTR_BITS+1)'(DEPTH));

endmodule

// File: source/mshr_file.sv
`include "dcache_settings.svh"

module mshr_file (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  logic                                                 load_valid,
    input  dcache_mem_pkg::addr_t                                load_addr,
    input  logic [`LQ_IDX_BITS-1:0]                              load_lq_idx,
    input  logic                                                 load_miss,
    input  logic                                                 store_valid,
    input  dcache_mem_pkg::addr_t                                store_addr,
    input  dcache_req_pkg::mem_func_t                            store_func,
    input  logic [31:0]                                          store_data,
    input  logic                                                 store_miss,
    input  logic                                                 evict,
    input  dcache_mem_pkg::mem_tag_t                             mem_transaction_tag,
    input  dcache_mem_pkg::mem_tag_t                             mem_data_tag,
    output logic                                                 load_accept_miss,
    output logic                                                 store_accept_miss,
    output logic                                                 issue_valid,
    output dcache_mem_pkg::addr_t                                issue_addr,
    output logic                                                 fill,
    output logic [`DCACHE_TAG_BITS-1:0]                          fill_tag,
    output logic [`DCACHE_INDEX_BITS-1:0]                        fill_index,
    output dcache_req_pkg::mshr_target_t [`MSHR_TARGET_DEPTH-1:0] fill_targets,
    output logic [`MSHR_TARGET_DEPTH-1:0]                        fill_valid
);
    import dcache_mem_pkg::*;
    import dcache_req_pkg::*;

    typedef enum logic [1:0] {
        ENTRY_INVALID,
        ENTRY_PENDING,
        ENTRY_WAIT_DATA
    } entry_state_t;

    localparam int N         = `MSHR_ENTRIES;
    localparam int LINE_BITS = `DCACHE_TAG_BITS + `DCACHE_INDEX_BITS;

    entry_state_t         state [N];
    logic [LINE_BITS-1:0] entry_line [N];
    mem_tag_t             entry_txn [N];
    logic [N-1:0]         entry_has_load;

    logic [LINE_BITS-1:0] load_line;
    logic [LINE_BITS-1:0] store_line;
    logic [N-1:0]         live, pending, load_match, store_match, fill_hit;
    logic [N-1:0]         load_sel, store_sel, load_alloc, store_alloc;
    logic [N-1:0]         push, push_accept, issue_grant;
    mshr_target_t         load_target;
    mshr_target_t         store_target;
    mshr_target_t         push_target [N];
    mshr_target_t [`MSHR_TARGET_DEPTH-1:0] drain_targets [N];
    logic [`MSHR_TARGET_DEPTH-1:0]         drain_valid [N];

    assign load_line    = load_addr[31:`DCACHE_OFFSET_BITS];
    assign store_line   = store_addr[31:`DCACHE_OFFSET_BITS];
    assign load_target  = '{TARGET_LOAD, MEM_WORD, 32'd0,
                            load_addr[`DCACHE_OFFSET_BITS-1:0], load_lq_idx};
    assign store_target = '{TARGET_STORE, store_func, store_data,
                            store_addr[`DCACHE_OFFSET_BITS-1:0], '0};

    for (genvar i = 0; i < N; i++) begin : g_entry
        assign live[i]        = state[i] != ENTRY_INVALID;
        assign pending[i]     = state[i] == ENTRY_PENDING;
        assign load_match[i]  = live[i] && entry_line[i] == load_line;
        assign store_match[i] = live[i] && entry_line[i] == store_line;
        // waiting tags are never zero
        assign fill_hit[i]    = state[i] == ENTRY_WAIT_DATA && entry_txn[i] == mem_data_tag;
        assign push[i]        = load_sel[i] || store_sel[i];
        assign push_target[i] = load_sel[i] ? load_target : store_target;

        mshr_target_queue u_queue (
            .clock(clock),
            .reset(reset),
            .push(push[i]),
            .push_target(push_target[i]),
            .flush(fill_hit[i]),
            .push_accept(push_accept[i]),
            .drain_targets(drain_targets[i]),
            .drain_valid(drain_valid[i])
        );
    end

    always_comb begin
        logic [N-1:0] free;
        logic [N-1:0] store_entry;
        free       = ~live;
        load_sel   = '0;
        load_alloc = '0;
        if (load_valid && load_miss) begin
            if (|load_match) begin
                // one load per entry so a fill returns at most one
                load_sel = load_match & ~entry_has_load;
            end else begin
                load_sel   = free & (~free + 1'b1);
                load_alloc = load_sel;
            end
        end
        // store sees the entry the load just took
        free        = free & ~load_alloc;
        store_entry = store_match;
        if (|load_alloc && store_line == load_line) begin
            store_entry = load_alloc;
        end
        store_sel   = '0;
        store_alloc = '0;
        if (store_valid && store_miss) begin
            if (|store_entry) begin
                store_sel = store_entry;
            end else begin
                store_sel   = free & (~free + 1'b1);
                store_alloc = store_sel;
            end
            // a queue takes one push per cycle, store retries
            if (|(store_sel & load_sel)) begin
                store_sel   = '0;
                store_alloc = '0;
            end
        end
    end

    assign load_accept_miss  = |(load_sel & push_accept);
    assign store_accept_miss = |(store_sel & push_accept);

    always_comb begin
        issue_grant = evict ? '0 : pending & (~pending + 1'b1);
        issue_valid = |issue_grant;
        issue_addr  = '0;
        for (int i = 0; i < N; i++) begin
            if (issue_grant[i]) begin
                issue_addr = {entry_line[i], {`DCACHE_OFFSET_BITS{1'b0}}};
            end
        end
    end

    always_comb begin
        fill         = |fill_hit;
        fill_tag     = '0;
        fill_index   = '0;
        fill_targets = '0;
        fill_valid   = '0;
        for (int i = 0; i < N; i++) begin
            if (fill_hit[i]) begin
                {fill_tag, fill_index} = entry_line[i];
                fill_targets           = drain_targets[i];
                fill_valid             = drain_valid[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                state[i] <= ENTRY_INVALID;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (fill_hit[i]) begin
                    state[i] <= ENTRY_INVALID;
                end else if (load_alloc[i] || store_alloc[i]) begin
                    state[i] <= ENTRY_PENDING;
                end else if (issue_grant[i] && mem_transaction_tag != '0) begin
                    state[i] <= ENTRY_WAIT_DATA;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < N; i++) begin
            if (load_alloc[i]) begin
                entry_line[i] <= load_line;
            end else if (store_alloc[i]) begin
                entry_line[i] <= store_line;
            end
            if (issue_grant[i]) begin
                entry_txn[i] <= mem_transaction_tag;
            end
            if (load_sel[i] && push_accept[i]) begin
                entry_has_load[i] <= 1'b1;
            end else if (store_alloc[i]) begin
                entry_has_load[i] <= 1'b0;
            end
        end
    end

    // memory hands out each tag to one request at a time
    assert property (@(posedge clock) disable iff (reset) $onehot0(fill_hit));

    for (genvar i = 0; i < N; i++) begin : g_unique
        for (genvar j = i + 1; j < N; j++) begin : g_pair
            assert property (@(posedge clock) disable iff (reset)
                !(live[i] && live[j] && entry_line[i] == entry_line[j]));
        end
    end

endmodule

// File: source/dcache_line_array.sv
`include "dcache_settings.svh"

module dcache_line_array (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  logic                                                 load_valid,
    input  dcache_mem_pkg::addr_t                                load_addr,
    input  logic                                                 store_valid,
    input  dcache_mem_pkg::addr_t                                store_addr,
    input  dcache_req_pkg::mem_func_t                            store_func,
    input  logic [31:0]                                          store_data,
    input  logic                                                 fill,
    input  logic [`DCACHE_TAG_BITS-1:0]                          fill_tag,
    input  logic [`DCACHE_INDEX_BITS-1:0]                        fill_index,
    input  dcache_req_pkg::mshr_target_t [`MSHR_TARGET_DEPTH-1:0] fill_targets,
    input  logic [`MSHR_TARGET_DEPTH-1:0]                        fill_valid,
    input  dcache_mem_pkg::mem_block_t                           mem_data,
    input  logic                                                 issue_valid,
    input  dcache_mem_pkg::addr_t                                issue_addr,
    input  logic                                                 load_accept_miss,
    input  logic                                                 store_accept_miss,
    output logic                                                 load_accept,
    output dcache_mem_pkg::mem_block_t                           load_data,
    output logic                                                 load_data_valid,
    output logic                                                 store_accept,
    output logic                                                 load_miss,
    output logic                                                 store_miss,
    output logic                                                 evict,
    output logic                                                 fill_load_valid,
    output logic [`LQ_IDX_BITS-1:0]                              fill_load_lq_idx,
    output dcache_mem_pkg::mem_block_t                           fill_load_data,
    output dcache_mem_pkg::mem_command_t                         mem_command,
    output dcache_mem_pkg::addr_t                                mem_addr,
    output dcache_mem_pkg::mem_block_t                           mem_wdata
);
    import dcache_mem_pkg::*;
    import dcache_req_pkg::*;

    localparam int LINES   = 1 << `DCACHE_INDEX_BITS;
    localparam int TAG_LSB = `DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS;

    mem_block_t                  line_data [LINES];
    logic [`DCACHE_TAG_BITS-1:0] line_tag [LINES];
    logic [LINES-1:0]            line_valid;
    logic [LINES-1:0]            line_dirty;

    logic [`DCACHE_INDEX_BITS-1:0] load_index, store_index;
    logic [`DCACHE_TAG_BITS-1:0]   load_tag, store_tag;
    mem_block_t                    fill_block, store_view, store_block;
    logic                          fill_dirty, load_hit, store_hit;

    assign load_index  = load_addr[TAG_LSB-1:`DCACHE_OFFSET_BITS];
    assign load_tag    = load_addr[31:TAG_LSB];
    assign store_index = store_addr[TAG_LSB-1:`DCACHE_OFFSET_BITS];
    assign store_tag   = store_addr[31:TAG_LSB];

    // replay drained targets over the returning block in order
    always_comb begin
        fill_block       = mem_data;
        fill_dirty       = 1'b0;
        fill_load_valid  = 1'b0;
        fill_load_lq_idx = '0;
        fill_load_data   = '0;
        for (int i = 0; i < `MSHR_TARGET_DEPTH; i++) begin
            if (fill && fill_valid[i]) begin
                if (fill_targets[i].kind == TARGET_STORE) begin
                    fill_block = merge_store(fill_block, fill_targets[i].size,
                                             fill_targets[i].offset, fill_targets[i].data);
                    fill_dirty = 1'b1;
                end else if (!fill_load_valid) begin
                    fill_load_valid  = 1'b1;
                    fill_load_lq_idx = fill_targets[i].lq_idx;
                    fill_load_data   = fill_block;
                end
            end
        end
    end

    // lookups see the line as the fill leaves it
    always_comb begin
        if (fill && fill_index == load_index) begin
            load_hit  = load_valid && fill_tag == load_tag;
            load_data = fill_block;
        end else begin
            load_hit  = load_valid && line_valid[load_index] && line_tag[load_index] == load_tag;
            load_data = line_data[load_index];
        end
        if (fill && fill_index == store_index) begin
            store_hit  = store_valid && fill_tag == store_tag;
            store_view = fill_block;
        end else begin
            store_hit  = store_valid && line_valid[store_index]
                         && line_tag[store_index] == store_tag;
            store_view = line_data[store_index];
        end
        store_block = merge_store(store_view, store_func,
                                  store_addr[`DCACHE_OFFSET_BITS-1:0], store_data);
    end

    assign load_data_valid = load_hit;
    assign load_miss       = load_valid && !load_hit;
    assign load_accept     = load_hit || load_accept_miss;
    assign store_miss      = store_valid && !store_hit;
    assign store_accept    = store_hit || store_accept_miss;

    // dirty victim goes out before any new request
    assign evict = fill && line_valid[fill_index] && line_dirty[fill_index];

    always_comb begin
        mem_command = MEM_NONE;
        mem_addr    = '0;
        mem_wdata   = '0;
        if (evict) begin
            mem_command = MEM_STORE;
            mem_addr    = {line_tag[fill_index], fill_index, {`DCACHE_OFFSET_BITS{1'b0}}};
            mem_wdata   = line_data[fill_index];
        end else if (issue_valid) begin
            mem_command = MEM_LOAD;
            mem_addr    = issue_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else begin
            if (fill) begin
                line_valid[fill_index] <= 1'b1;
                line_dirty[fill_index] <= fill_dirty;
            end
            if (store_hit) begin
                line_dirty[store_index] <= 1'b1;
            end
        end
    end

    // store merge already includes a same-line fill
    always_ff @(posedge clock) begin
        if (fill) begin
            line_data[fill_index] <= fill_block;
            line_tag[fill_index]  <= fill_tag;
        end
        if (store_hit) begin
            line_data[store_index] <= store_block;
        end
    end

endmodule

// File: source/dcache_top.sv
`include "dcache_settings.svh"

module dcache_top (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         load_valid,
    input  dcache_mem_pkg::addr_t        load_addr,
    input  logic [`LQ_IDX_BITS-1:0]      load_lq_idx,
    output logic                         load_accept,
    output dcache_mem_pkg::mem_block_t   load_data,
    output logic                         load_data_valid,
    input  logic                         store_valid,
    input  dcache_mem_pkg::addr_t        store_addr,
    input  dcache_req_pkg::mem_func_t    store_func,
    input  logic [31:0]                  store_data,
    output logic                         store_accept,
    output logic                         fill_load_valid,
    output logic [`LQ_IDX_BITS-1:0]      fill_load_lq_idx,
    output dcache_mem_pkg::mem_block_t   fill_load_data,
    output dcache_mem_pkg::mem_command_t mem_command,
    output dcache_mem_pkg::addr_t        mem_addr,
    output dcache_mem_pkg::mem_block_t   mem_wdata,
    input  dcache_mem_pkg::mem_tag_t     mem_transaction_tag,
    input  dcache_mem_pkg::mem_block_t   mem_data,
    input  dcache_mem_pkg::mem_tag_t     mem_data_tag
);
    import dcache_mem_pkg::*;
    import dcache_req_pkg::*;

    logic                                  load_miss, store_miss, evict;
    logic                                  load_accept_miss, store_accept_miss;
    logic                                  issue_valid;
    addr_t                                 issue_addr;
    logic                                  fill;
    logic [`DCACHE_TAG_BITS-1:0]           fill_tag;
    logic [`DCACHE_INDEX_BITS-1:0]         fill_index;
    mshr_target_t [`MSHR_TARGET_DEPTH-1:0] fill_targets;
    logic [`MSHR_TARGET_DEPTH-1:0]         fill_valid;

    // misses and fill bookkeeping
    mshr_file u_mshr (.*);

    dcache_line_array u_lines (.*);

endmodule

// File: tb/dcache_checker.sv
`include "dcache_settings.svh"

module dcache_checker (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         load_valid,
    input  dcache_mem_pkg::addr_t        load_addr,
    input  logic [`LQ_IDX_BITS-1:0]      load_lq_idx,
    input  logic                         load_accept,
    input  dcache_mem_pkg::mem_block_t   load_data,
    input  logic                         load_data_valid,
    input  logic                         store_valid,
    input  dcache_mem_pkg::addr_t        store_addr,
    input  dcache_req_pkg::mem_func_t    store_func,
    input  logic [31:0]                  store_data,
    input  logic                         store_accept,
    input  logic                         fill_load_valid,
    input  logic [`LQ_IDX_BITS-1:0]      fill_load_lq_idx,
    input  dcache_mem_pkg::mem_block_t   fill_load_data,
    input  dcache_mem_pkg::mem_command_t mem_command,
    input  dcache_mem_pkg::addr_t        mem_addr,
    input  dcache_mem_pkg::mem_block_t   mem_wdata,
    output int                           check_count,
    output int                           error_count,
    output int                           outstanding_loads
);
    timeunit 1ns;
    timeprecision 100ps;

    import dcache_mem_pkg::*;
    import dcache_req_pkg::*;

    localparam int LQ_SLOTS = 1 << `LQ_IDX_BITS;

    mem_block_t          shadow [addr_t];
    mem_block_t          expected_fill [LQ_SLOTS];
    logic [LQ_SLOTS-1:0] outstanding = '0;
    int                  checks = 0;
    int                  errors = 0;

    assign check_count       = checks;
    assign error_count       = errors;
    assign outstanding_loads = $countones(outstanding);

    function automatic addr_t line_key(input addr_t addr);
        return {addr[31:`DCACHE_OFFSET_BITS], {`DCACHE_OFFSET_BITS{1'b0}}};
    endfunction

    // same contents the memory model starts from
    function automatic mem_block_t block_pattern(input addr_t block_addr);
        return {block_addr ^ 32'h9e37_79b9, ~block_addr};
    endfunction

    function automatic mem_block_t read_shadow(input addr_t addr);
        addr_t key;
        key = line_key(addr);
        return shadow.exists(key) ? shadow[key] : block_pattern(key);
    endfunction

    // byte lane picked by size, then bytes copied low first
    function automatic mem_block_t apply_store(input mem_block_t block, input mem_func_t func,
                                               input logic [2:0] offset, input logic [31:0] data);
        int lane;
        int width;
        case (func)
            MEM_BYTE: begin
                lane  = int'(offset);
                width = 1;
            end
            MEM_HALF: begin
                lane  = int'({offset[2:1], 1'b0});
                width = 2;
            end
            default: begin
                lane  = int'({offset[2], 2'b00});
                width = 4;
            end
        endcase
        for (int b = 0; b < width; b++) begin
            block[(lane + b) * 8 +: 8] = data[b * 8 +: 8];
        end
        return block;
    endfunction

    task automatic compare_block(input string name, input mem_block_t expected,
                                 input mem_block_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // fill first, then load lookup, then store
    always @(negedge clock) begin
        if (!reset) begin
            if (fill_load_valid) begin
                if (!outstanding[fill_load_lq_idx]) begin
                    errors++;
                    $display("fill returned load index %0d with no load outstanding at %0t",
                             fill_load_lq_idx, $time);
                end else begin
                    compare_block("fill_load_data", expected_fill[fill_load_lq_idx],
                                  fill_load_data);
                    outstanding[fill_load_lq_idx] = 1'b0;
                end
            end
            if (mem_command == MEM_STORE) begin
                compare_block("mem_wdata", read_shadow(mem_addr), mem_wdata);
            end
            if (load_valid && load_accept) begin
                if (load_data_valid) begin
                    compare_block("load_data", read_shadow(load_addr), load_data);
                end else if (outstanding[load_lq_idx]) begin
                    errors++;
                    $display("load index %0d accepted again before its result at %0t",
                             load_lq_idx, $time);
                end else begin
                    expected_fill[load_lq_idx] = read_shadow(load_addr);
                    outstanding[load_lq_idx]   = 1'b1;
                end
            end
            if (store_valid && store_accept) begin
                shadow[line_key(store_addr)] = apply_store(read_shadow(store_addr), store_func,
                                                           store_addr[2:0], store_data);
            end
        end
    end

endmodule

// File: tb/dcache_tb.sv
`include "dcache_settings.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import dcache_mem_pkg::*;
    import dcache_req_pkg::*;

    localparam int STIM_CYCLES    = 3000;
    localparam int DRAIN_CYCLES   = 2000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + DRAIN_CYCLES;
    localparam int TAGS           = 1 << `MEM_TAG_BITS;

    logic                    clock = 1'b0;
    logic                    reset;
    logic                    load_valid;
    addr_t                   load_addr;
    logic [`LQ_IDX_BITS-1:0] load_lq_idx;
    logic                    load_accept;
    mem_block_t              load_data;
    logic                    load_data_valid;
    logic                    store_valid;
    addr_t                   store_addr;
    mem_func_t               store_func;
    logic [31:0]             store_data;
    logic                    store_accept;
    logic                    fill_load_valid;
    logic [`LQ_IDX_BITS-1:0] fill_load_lq_idx;
    mem_block_t              fill_load_data;
    mem_command_t            mem_command;
    addr_t                   mem_addr;
    mem_block_t              mem_wdata;
    mem_tag_t                mem_transaction_tag;
    mem_block_t              mem_data;
    mem_tag_t                mem_data_tag;
    int                      check_count;
    int                      error_count;
    int                      outstanding_loads;

    int                      cycle_count = 0;
    logic                    load_taken;
    logic                    store_taken;
    logic [`LQ_IDX_BITS-1:0] free_idx [$];

    mem_block_t              backing [addr_t];
    mem_block_t              held_data [TAGS];
    int                      held_due [TAGS];
    logic [TAGS-1:0]         busy;
    mem_tag_t                offer_tag;

    dcache_top u_dut (.*);

    dcache_checker u_check (.*);

    always #10 clock = ~clock;

    // memory answers a load command in the same cycle
    assign mem_transaction_tag = (mem_command == MEM_LOAD) ? offer_tag : '0;

    function automatic mem_block_t block_pattern(input addr_t block_addr);
        return {block_addr ^ 32'h9e37_79b9, ~block_addr};
    endfunction

    function automatic mem_block_t read_backing(input addr_t addr);
        addr_t key;
        key = {addr[31:`DCACHE_OFFSET_BITS], {`DCACHE_OFFSET_BITS{1'b0}}};
        return backing.exists(key) ? backing[key] : block_pattern(key);
    endfunction

    // 4 tags over 4 indices, any offset
    function automatic addr_t random_addr();
        int unsigned pick_tag;
        int unsigned pick_index;
        pick_tag   = $urandom_range(0, 3);
        pick_index = $urandom_range(0, 3);
        return {22'h2a5c3, pick_tag[1:0], pick_index[1:0], 3'b101, 3'($urandom_range(0, 7))};
    endfunction

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d loads unanswered and %0d errors",
                     cycle_count, outstanding_loads, error_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // memory model, at most one return per cycle
    initial begin
        int start;
        int pick;
        offer_tag    = '0;
        mem_data_tag = '0;
        mem_data     = '0;
        busy         = '0;
        forever begin
            @(posedge clock);
            #1;
            mem_data_tag = '0;
            mem_data     = '0;
            for (int t = 1; t < TAGS; t++) begin
                if (busy[t] && held_due[t] <= cycle_count && mem_data_tag == '0) begin
                    mem_data_tag = mem_tag_t'(t);
                    mem_data     = held_data[t];
                end
            end
            offer_tag = '0;
            start     = int'($urandom_range(1, TAGS - 1));
            if ($urandom_range(0, 3) != 0) begin
                for (int k = 0; k < TAGS - 1; k++) begin
                    pick = 1 + (start - 1 + k) % (TAGS - 1);
                    if (!busy[pick] && offer_tag == '0) begin
                        offer_tag = mem_tag_t'(pick);
                    end
                end
            end
            @(negedge clock);
            if (!reset) begin
                if (mem_data_tag != '0) begin
                    busy[mem_data_tag] = 1'b0;
                end
                if (mem_command == MEM_LOAD && mem_transaction_tag != '0) begin
                    busy[mem_transaction_tag]      = 1'b1;
                    held_data[mem_transaction_tag] = read_backing(mem_addr);
                    held_due[mem_transaction_tag]  = cycle_count + int'($urandom_range(2, 12));
                end else if (mem_command == MEM_STORE) begin
                    backing[{mem_addr[31:`DCACHE_OFFSET_BITS], {`DCACHE_OFFSET_BITS{1'b0}}}] =
                        mem_wdata;
                end
            end
        end
    end

    initial begin
        void'($urandom(97));
        reset       = 1'b1;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_lq_idx = '0;
        store_valid = 1'b0;
        store_addr  = '0;
        store_func  = MEM_BYTE;
        store_data  = '0;
        load_taken  = 1'b0;
        store_taken = 1'b0;
        for (int i = 0; i < (1 << `LQ_IDX_BITS); i++) begin
            free_idx.push_back(i[`LQ_IDX_BITS-1:0]);
        end
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        // requests stay up until accepted
        for (int n = 0; n < STIM_CYCLES || load_valid || store_valid; n++) begin
            @(posedge clock);
            #1;
            if (load_taken) begin
                load_valid = 1'b0;
            end
            if (store_taken) begin
                store_valid = 1'b0;
            end
            if (n < STIM_CYCLES && !load_valid && free_idx.size() != 0
                    && $urandom_range(0, 9) < 6) begin
                load_valid  = 1'b1;
                load_addr   = random_addr();
                load_lq_idx = free_idx.pop_front();
            end
            if (n < STIM_CYCLES && !store_valid && $urandom_range(0, 9) < 5) begin
                store_valid = 1'b1;
                store_addr  = random_addr();
                store_func  = mem_func_t'($urandom_range(0, 2));
                store_data  = $urandom();
            end
            @(negedge clock);
            load_taken  = load_valid && load_accept;
            store_taken = store_valid && store_accept;
            if (load_taken && load_data_valid) begin
                free_idx.push_back(load_lq_idx);
            end
            if (fill_load_valid) begin
                free_idx.push_back(fill_load_lq_idx);
            end
        end

        // every miss has to come back
        while (outstanding_loads != 0) begin
            @(negedge clock);
        end
        repeat (4) @(posedge clock);

        $display("checks %0d, errors %0d, loads outstanding %0d",
                 check_count, error_count, outstanding_loads);
        if (error_count == 0 && outstanding_loads == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/dcache_mem_pkg.sv
source/dcache_req_pkg.sv
source/mshr_target_queue.sv
source/mshr_file.sv
source/dcache_line_array.sv
source/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
